/* logic/soc_fabric_pkg.sv */
package soc_fabric_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  // All zero means a read
  typedef logic [3:0]  strb_t;
  typedef logic [11:0] word_idx_t;
  typedef logic [1:0]  bank_sel_t;
  typedef logic [3:0]  led_t;

  // Memory map
  localparam addr_t TEXT_BASE   = 32'h0000_0000;
  localparam addr_t HEAP_BASE   = 32'h0001_0000;
  localparam addr_t REGION_SIZE = 32'h0001_0000;
  localparam addr_t LED_ADDR    = 32'h8000_0000;

  // RAM geometry, 4 banks x 4096 words x 4 bytes = 64 KB
  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 4096;

  typedef enum logic {
    OWN_CPU,
    OWN_DMA
  } heap_owner_e;

endpackage

/* logic/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;
  import soc_fabric_pkg::*;

  logic  valid;
  addr_t addr;
  data_t wdata;
  strb_t wstrb;
  logic  ready;
  // Valid in the ready cycle only
  data_t rdata;

  modport requester (
    output valid,
    output addr,
    output wdata,
    output wstrb,
    input  ready,
    input  rdata
  );

  modport responder (
    input  valid,
    input  addr,
    input  wdata,
    input  wstrb,
    output ready,
    output rdata
  );

endinterface

/* logic/ram_bank.sv */
`timescale 1ns/1ps

module ram_bank (
  input  logic                      clk,
  input  logic                      en,
  input  soc_fabric_pkg::word_idx_t idx,
  input  soc_fabric_pkg::data_t     wdata,
  input  soc_fabric_pkg::strb_t     wstrb,
  output soc_fabric_pkg::data_t     rdata
);
  import soc_fabric_pkg::*;

  // One byte-wide memory per lane
  for (genvar l = 0; l < 4; l++) begin : g_lane
    logic [7:0] mem [BANK_WORDS];
    logic [7:0] lane_q;

    always_ff @(posedge clk) begin
      if (en) begin
        if (wstrb[l]) begin
          mem[idx] <= wdata[8*l +: 8];
          lane_q   <= wdata[8*l +: 8];
        end else begin
          lane_q <= mem[idx];
        end
      end
    end

    assign rdata[8*l +: 8] = lane_q;
  end

endmodule

/* logic/banked_ram.sv */
`timescale 1ns/1ps

module banked_ram (
  input  logic         clk,
  input  logic         resetn,
  mem_bus_if.responder bus
);
  import soc_fabric_pkg::*;

  bank_sel_t bank_sel;
  word_idx_t word_idx;
  bank_sel_t sel_d1;
  bank_sel_t sel_d2;
  logic      is_write;
  logic      valid_q;
  logic      ready_wr;
  logic      ready_rd;
  data_t     bank_rdata [NUM_BANKS];
  data_t     bank_rdata_q [NUM_BANKS];

  // Low 16 bits are the offset inside the region
  assign bank_sel = bus.addr[15:14];
  assign word_idx = bus.addr[13:2];
  assign is_write = |bus.wstrb;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    strb_t bank_wstrb;

    // Strobes reach the addressed bank once, before ready
    assign bank_wstrb = (bus.valid && !bus.ready && (bank_sel == bank_sel_t'(b))) ?
                        bus.wstrb : '0;

    ram_bank u_bank (
      .clk   (clk),
      .en    (bus.valid),
      .idx   (word_idx),
      .wdata (bus.wdata),
      .wstrb (bank_wstrb),
      .rdata (bank_rdata[b])
    );
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q  <= 1'b0;
      ready_wr <= 1'b0;
      ready_rd <= 1'b0;
    end else begin
      valid_q  <= bus.valid;
      // One pulse per request, on its second cycle
      ready_wr <= bus.valid && !valid_q;
      ready_rd <= ready_wr && !is_write;
    end
  end

  // Output stage, bank number follows the data two cycles behind
  always_ff @(posedge clk) begin
    bank_rdata_q <= bank_rdata;
    sel_d1       <= bank_sel;
    sel_d2       <= sel_d1;
  end

  assign bus.ready = (ready_wr && is_write) || ready_rd;
  assign bus.rdata = bank_rdata_q[sel_d2];

  a_ready_with_valid : assert property (@(posedge clk) disable iff (!resetn)
    bus.ready |-> bus.valid);

endmodule

/* logic/led_port.sv */
`timescale 1ns/1ps

module led_port (
  input  logic                 clk,
  input  logic                 resetn,
  mem_bus_if.responder         bus,
  output soc_fabric_pkg::led_t led
);
  import soc_fabric_pkg::*;

  led_t led_q;
  logic ready_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      led_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= bus.valid && !ready_q;
      // Latched on the handshake edge, so led moves the cycle after ready
      if (bus.valid && ready_q && (|bus.wstrb)) begin
        led_q <= bus.wdata[$bits(led_t)-1:0];
      end
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = data_t'(led_q);
  assign led       = led_q;

endmodule

/* logic/bus_ctrl.sv */
`timescale 1ns/1ps

module bus_ctrl (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  cpu_valid,
  input  soc_fabric_pkg::addr_t cpu_addr,
  input  soc_fabric_pkg::data_t cpu_wdata,
  input  soc_fabric_pkg::strb_t cpu_wstrb,
  output logic                  cpu_ready,
  output soc_fabric_pkg::data_t cpu_rdata,
  input  logic                  dma_bus_req,
  output logic                  dma_bus_grant,
  input  logic                  dma_valid,
  input  soc_fabric_pkg::addr_t dma_addr,
  input  soc_fabric_pkg::data_t dma_wdata,
  input  soc_fabric_pkg::strb_t dma_wstrb,
  output logic                  dma_ready,
  output soc_fabric_pkg::data_t dma_rdata,
  mem_bus_if.requester          text_bus,
  mem_bus_if.requester          heap_bus,
  mem_bus_if.requester          led_bus
);
  import soc_fabric_pkg::*;

  logic        hit_text;
  logic        hit_heap;
  logic        hit_led;
  logic        hit_none;
  logic        cpu_heap_req;
  logic        cpu_heap_busy;
  logic        unmapped_ready;
  heap_owner_e owner_q;

  // Offsets wrap below the base, so one unsigned compare covers both ends
  assign hit_text = cpu_valid && (addr_t'(cpu_addr - TEXT_BASE) < REGION_SIZE);
  assign hit_heap = cpu_valid && (addr_t'(cpu_addr - HEAP_BASE) < REGION_SIZE);
  assign hit_led  = cpu_valid && (cpu_addr == LED_ADDR);
  assign hit_none = cpu_valid && !hit_text && !hit_heap && !hit_led;

  assign dma_bus_grant = (owner_q == OWN_DMA);
  assign cpu_heap_req  = hit_heap && !dma_bus_grant;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      owner_q        <= OWN_CPU;
      cpu_heap_busy  <= 1'b0;
      unmapped_ready <= 1'b0;
    end else begin
      case (owner_q)
        OWN_CPU: begin
          // Hand over only between CPU transfers
          if (dma_bus_req && !cpu_heap_req && !cpu_heap_busy) begin
            owner_q <= OWN_DMA;
          end
        end
        OWN_DMA: begin
          if (!dma_bus_req) begin
            owner_q <= OWN_CPU;
          end
        end
      endcase
      cpu_heap_busy  <= cpu_heap_req && !heap_bus.ready;
      unmapped_ready <= hit_none && !unmapped_ready;
    end
  end

  assign text_bus.valid = hit_text;
  assign text_bus.addr  = cpu_addr;
  assign text_bus.wdata = cpu_wdata;
  assign text_bus.wstrb = cpu_wstrb;

  assign led_bus.valid = hit_led;
  assign led_bus.addr  = cpu_addr;
  assign led_bus.wdata = cpu_wdata;
  assign led_bus.wstrb = cpu_wstrb;

  // Heap port follows the owner
  always_comb begin
    if (dma_bus_grant) begin
      heap_bus.valid = dma_valid;
      heap_bus.addr  = dma_addr;
      heap_bus.wdata = dma_wdata;
      heap_bus.wstrb = dma_wstrb;
    end else begin
      heap_bus.valid = cpu_heap_req;
      heap_bus.addr  = cpu_addr;
      heap_bus.wdata = cpu_wdata;
      heap_bus.wstrb = cpu_wstrb;
    end
  end

  always_comb begin
    cpu_ready = 1'b0;
    cpu_rdata = '0;
    if (hit_text) begin
      cpu_ready = text_bus.ready;
      cpu_rdata = text_bus.rdata;
    end else if (hit_heap) begin
      cpu_ready = cpu_heap_req && heap_bus.ready;
      cpu_rdata = heap_bus.rdata;
    end else if (hit_led) begin
      cpu_ready = led_bus.ready;
      cpu_rdata = led_bus.rdata;
    end else if (hit_none) begin
      cpu_ready = unmapped_ready;
    end
  end

  assign dma_ready = dma_bus_grant && heap_bus.ready;
  assign dma_rdata = dma_bus_grant ? heap_bus.rdata : '0;

  // Heap RAM must be idle when ownership moves to the DMA
  a_grant_heap_idle : assert property (@(posedge clk) disable iff (!resetn)
    $rose(dma_bus_grant) |-> !heap_bus.ready);

  // A DMA transfer lasts at least two cycles, all of them under the grant
  a_dma_ready_granted : assert property (@(posedge clk) disable iff (!resetn)
    dma_ready |-> $past(dma_bus_grant));

endmodule

/* logic/soc_fabric.sv */
`timescale 1ns/1ps

module soc_fabric (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  cpu_valid,
  input  soc_fabric_pkg::addr_t cpu_addr,
  input  soc_fabric_pkg::data_t cpu_wdata,
  input  soc_fabric_pkg::strb_t cpu_wstrb,
  output logic                  cpu_ready,
  output soc_fabric_pkg::data_t cpu_rdata,
  input  logic                  dma_bus_req,
  output logic                  dma_bus_grant,
  input  logic                  dma_valid,
  input  soc_fabric_pkg::addr_t dma_addr,
  input  soc_fabric_pkg::data_t dma_wdata,
  input  soc_fabric_pkg::strb_t dma_wstrb,
  output logic                  dma_ready,
  output soc_fabric_pkg::data_t dma_rdata,
  output soc_fabric_pkg::led_t  led
);

  mem_bus_if text_bus ();
  mem_bus_if heap_bus ();
  mem_bus_if led_bus ();

  bus_ctrl u_bus_ctrl (
    .clk           (clk),
    .resetn        (resetn),
    .cpu_valid     (cpu_valid),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_wstrb     (cpu_wstrb),
    .cpu_ready     (cpu_ready),
    .cpu_rdata     (cpu_rdata),
    .dma_bus_req   (dma_bus_req),
    .dma_bus_grant (dma_bus_grant),
    .dma_valid     (dma_valid),
    .dma_addr      (dma_addr),
    .dma_wdata     (dma_wdata),
    .dma_wstrb     (dma_wstrb),
    .dma_ready     (dma_ready),
    .dma_rdata     (dma_rdata),
    .text_bus      (text_bus.requester),
    .heap_bus      (heap_bus.requester),
    .led_bus       (led_bus.requester)
  );

  banked_ram text_ram (
    .clk    (clk),
    .resetn (resetn),
    .bus    (text_bus.responder)
  );

  // Shared between CPU and DMA through bus_ctrl
  banked_ram heap_ram (
    .clk    (clk),
    .resetn (resetn),
    .bus    (heap_bus.responder)
  );

  led_port u_led_port (
    .clk    (clk),
    .resetn (resetn),
    .bus    (led_bus.responder),
    .led    (led)
  );

endmodule

/* tb/tb_soc_fabric.sv */
`timescale 1ns/1ps

module tb_soc_fabric;
  import soc_fabric_pkg::*;

  localparam int TIMEOUT = 50;

  logic  clk;
  logic  resetn;
  logic  cpu_valid;
  addr_t cpu_addr;
  data_t cpu_wdata;
  strb_t cpu_wstrb;
  logic  cpu_ready;
  data_t cpu_rdata;
  logic  dma_bus_req;
  logic  dma_bus_grant;
  logic  dma_valid;
  addr_t dma_addr;
  data_t dma_wdata;
  strb_t dma_wstrb;
  logic  dma_ready;
  data_t dma_rdata;
  led_t  led;

  integer seed = 96;
  int     pass_count = 0;
  int     fail_count = 0;
  int     test_fails = 0;
  logic   grant_at_ready;
  data_t  text_model [addr_t];
  data_t  heap_model [addr_t];
  led_t   led_model;
  addr_t  filled_addrs [$];
  addr_t  text_probe;
  addr_t  heap_probe;

  soc_fabric dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic data_t rand32();
    return $random(seed);
  endfunction

  function automatic strb_t rand_strb();
    data_t r;
    r = rand32();
    return (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
  endfunction

  // Byte lanes under the strobes take the new data
  function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t strb);
    data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = nw[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic data_t model_word(input addr_t addr);
    return (addr >= HEAP_BASE) ? heap_model[addr] : text_model[addr];
  endfunction

  task automatic check_value(input string msg, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s, got %h expected %h", $time, msg, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout: %s within %0d cycles", what, TIMEOUT);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic test_done(input string name);
    $display("test %-20s finished with %0d errors", name, fail_count - test_fails);
    test_fails = fail_count;
  endtask

  task automatic cpu_start(input addr_t addr, input data_t wdata, input strb_t wstrb);
    @(posedge clk);
    cpu_valid <= 1'b1;
    cpu_addr  <= addr;
    cpu_wdata <= wdata;
    cpu_wstrb <= wstrb;
  endtask

  task automatic wait_cpu(output data_t rdata, output int lat);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!cpu_ready && cycles < TIMEOUT);
    if (!cpu_ready) begin
      abort_run("cpu_ready never rose");
    end else begin
      rdata          = cpu_rdata;
      grant_at_ready = dma_bus_grant;
      lat            = cycles - 1;
      cpu_valid     <= 1'b0;
    end
  endtask

  task automatic cpu_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                            output data_t rdata, output int lat);
    cpu_start(addr, wdata, wstrb);
    wait_cpu(rdata, lat);
  endtask

  task automatic dma_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                            output data_t rdata, output int lat);
    int cycles;
    @(posedge clk);
    dma_valid <= 1'b1;
    dma_addr  <= addr;
    dma_wdata <= wdata;
    dma_wstrb <= wstrb;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!dma_ready && cycles < TIMEOUT);
    if (!dma_ready) begin
      abort_run("dma_ready never rose");
    end else begin
      rdata      = dma_rdata;
      lat        = cycles - 1;
      dma_valid <= 1'b0;
    end
  endtask

  task automatic wait_grant(input logic level, output int lat);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (dma_bus_grant !== level && cycles < TIMEOUT);
    if (dma_bus_grant !== level) begin
      abort_run("dma_bus_grant did not reach the expected level");
    end else begin
      lat = cycles - 1;
    end
  endtask

  task automatic write_word(input addr_t addr, input data_t wdata, input strb_t wstrb);
    data_t rd;
    int    lat;
    cpu_access(addr, wdata, wstrb, rd, lat);
    check_value($sformatf("write %h latency", addr), lat, 1);
    if (addr >= HEAP_BASE) begin
      heap_model[addr] = merge_bytes(heap_model.exists(addr) ? heap_model[addr] : '0,
                                     wdata, wstrb);
    end else begin
      text_model[addr] = merge_bytes(text_model.exists(addr) ? text_model[addr] : '0,
                                     wdata, wstrb);
    end
  endtask

  task automatic read_word(input addr_t addr);
    data_t rd;
    int    lat;
    cpu_access(addr, '0, '0, rd, lat);
    check_value($sformatf("read %h data", addr), rd, model_word(addr));
    check_value($sformatf("read %h latency", addr), lat, 2);
  endtask

  // First round uses full strobes so no byte stays unwritten
  task automatic fill_and_verify(input addr_t base, input int n, input int rounds);
    filled_addrs.delete();
    for (int i = 0; i < n; i++) begin
      filled_addrs.push_back(base + (rand32() & 32'h0000_FFFC));
    end
    for (int r = 0; r < rounds; r++) begin
      for (int i = 0; i < n; i++) begin
        write_word(filled_addrs[i], rand32(), (r == 0) ? 4'hF : rand_strb());
      end
    end
    for (int i = 0; i < n; i++) begin
      read_word(filled_addrs[i]);
    end
  endtask

  initial begin
    data_t rd;
    data_t wd;
    int    lat;
    addr_t a;
    addr_t dma_addrs [6];
    resetn      = 1'b0;
    cpu_valid   = 1'b0;
    cpu_addr    = '0;
    cpu_wdata   = '0;
    cpu_wstrb   = '0;
    dma_bus_req = 1'b0;
    dma_valid   = 1'b0;
    dma_addr    = '0;
    dma_wdata   = '0;
    dma_wstrb   = '0;
    led_model   = '0;
    repeat (16) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    check_value("cpu_ready after reset", 32'(cpu_ready), 32'd0);
    check_value("dma_ready after reset", 32'(dma_ready), 32'd0);
    check_value("dma_bus_grant after reset", 32'(dma_bus_grant), 32'd0);
    check_value("led after reset", 32'(led), 32'd0);
    test_done("reset");

    fill_and_verify(TEXT_BASE, 20, 3);
    text_probe = filled_addrs[0];
    test_done("text ram");

    fill_and_verify(HEAP_BASE, 12, 2);
    heap_probe = filled_addrs[0];
    // Same low bits on both sides of the text/heap boundary
    write_word(TEXT_BASE, rand32(), 4'hF);
    write_word(HEAP_BASE - 4, rand32(), 4'hF);
    write_word(HEAP_BASE, rand32(), 4'hF);
    read_word(TEXT_BASE);
    read_word(HEAP_BASE - 4);
    read_word(HEAP_BASE);
    test_done("heap ram");

    @(posedge clk);
    dma_bus_req <= 1'b1;
    wait_grant(1'b1, lat);
    check_value("grant latency", lat, 1);
    for (int i = 0; i < 6; i++) begin
      a = HEAP_BASE + (rand32() & 32'h0000_FFFC);
      wd = rand32();
      dma_addrs[i] = a;
      heap_model[a] = wd;
      dma_access(a, wd, 4'hF, rd, lat);
      check_value("dma write latency", lat, 1);
    end
    // CPU heap read while the DMA still owns the heap
    cpu_start(dma_addrs[0], '0, '0);
    repeat (6) begin
      @(posedge clk);
      check_value("cpu_ready under grant", 32'(cpu_ready), 32'd0);
    end
    dma_bus_req <= 1'b0;
    wait_cpu(rd, lat);
    check_value("stalled read data", rd, heap_model[dma_addrs[0]]);
    check_value("grant at stalled ready", 32'(grant_at_ready), 32'd0);
    for (int i = 1; i < 6; i++) begin
      read_word(dma_addrs[i]);
    end
    @(posedge clk);
    dma_bus_req <= 1'b1;
    wait_grant(1'b1, lat);
    foreach (filled_addrs[i]) begin
      dma_access(filled_addrs[i], '0, '0, rd, lat);
      check_value("dma read data", rd, heap_model[filled_addrs[i]]);
      check_value("dma read latency", lat, 2);
    end
    @(posedge clk);
    dma_bus_req <= 1'b0;
    wait_grant(1'b0, lat);
    test_done("dma ownership");

    for (int i = 0; i < 8; i++) begin
      wd = rand32();
      cpu_access(LED_ADDR, wd, rand_strb(), rd, lat);
      led_model = wd[3:0];
      check_value("led write latency", lat, 1);
      @(posedge clk);
      check_value("led output", 32'(led), 32'(led_model));
    end
    cpu_access(LED_ADDR, '0, '0, rd, lat);
    check_value("led read data", rd, {28'h0, led_model});
    check_value("led read latency", lat, 1);
    a = 32'h0002_0000 | (text_probe & 32'h0000_FFFC);
    cpu_access(a, rand32(), 4'hF, rd, lat);
    check_value("unmapped write data", rd, 32'd0);
    check_value("unmapped write latency", lat, 1);
    cpu_access(a, '0, '0, rd, lat);
    check_value("unmapped read data", rd, 32'd0);
    check_value("unmapped read latency", lat, 1);
    // Same offset as the heap probe
    a = 32'h0002_0000 | (heap_probe & 32'h0000_FFFC);
    cpu_access(a, rand32(), 4'hF, rd, lat);
    check_value("unmapped write data", rd, 32'd0);
    check_value("unmapped write latency", lat, 1);
    read_word(text_probe);
    read_word(heap_probe);
    test_done("led and unmapped");

    $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* soc_fabric.f */
logic/soc_fabric_pkg.sv
logic/mem_bus_if.sv
logic/ram_bank.sv
logic/banked_ram.sv
logic/led_port.sv
logic/bus_ctrl.sv
logic/soc_fabric.sv
tb/tb_soc_fabric.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f soc_fabric.f \
  --top-module tb_soc_fabric -o tb_soc_fabric
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_fabric > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0
